// File: build.f
src/vga_timing_pkg.sv
src/vga_color_pkg.sv
src/vga_ctl.sv
src/fb_reader.sv
src/pixel_decode.sv
src/vga_subsys.sv
verif/vga_checker.sv
verif/tb_vga_subsys.sv

// File: Makefile
TOP = tb_vga_subsys

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

# the run passes only when the pass line shows up in the output
sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee /dev/stderr | grep -q "Simulation passed"

clean:
	rm -rf obj_dir

// File: verif/tb_vga_subsys.sv
module tb_vga_subsys import vga_color_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int width = 16;
	localparam int h_front_porch = 2;
	localparam int h_sync = 3;
	localparam int h_back_porch = 2;
	localparam int height = 8;
	localparam int v_front_porch = 1;
	localparam int v_sync = 2;
	localparam int v_back_porch = 1;
	localparam int scale_shift = 1;    // 2x2 pixel cells
	localparam int fb_depth = (width >> scale_shift) * (height >> scale_shift);
	localparam int addr_w = $clog2(fb_depth);
	localparam int pal_depth = 1 << pal_idx_w;
	localparam int frame_clocks = (width + h_front_porch + h_sync + h_back_porch) *
		(height + v_front_porch + v_sync + v_back_porch);
	localparam int wait_limit = 2 * frame_clocks;

	logic vga_clk = 1'b0;
	logic reset_n;
	logic fb_wr_en;
	logic [addr_w-1:0] fb_wr_addr;
	pixel_word_t fb_wr_data;
	logic pal_wr_en;
	logic [pal_idx_w-1:0] pal_wr_addr;
	rgb888_t pal_wr_data;
	logic [7:0] vga_red;
	logic [7:0] vga_green;
	logic [7:0] vga_blue;
	logic vga_hsync;
	logic vga_vsync;
	logic fb_hblank;
	logic fb_vblank;
	int error_count;
	int direct_count;
	int indexed_count;
	int other_errors = 0;   // timeouts and missing coverage
	integer seed;

	always #20 vga_clk = ~vga_clk;  // 40 ns period

	vga_subsys #(
		.width(width), .h_front_porch(h_front_porch), .h_sync(h_sync),
		.h_back_porch(h_back_porch), .height(height), .v_front_porch(v_front_porch),
		.v_sync(v_sync), .v_back_porch(v_back_porch), .scale_shift(scale_shift)
	) u_dut (.*);

	vga_checker #(
		.width(width), .h_front_porch(h_front_porch), .h_sync(h_sync),
		.h_back_porch(h_back_porch), .height(height), .v_front_porch(v_front_porch),
		.v_sync(v_sync), .v_back_porch(v_back_porch), .scale_shift(scale_shift)
	) u_chk (.*);

	task automatic step_clock();
		@(posedge vga_clk);
		#2;                 // inputs move just after the edge
	endtask

	task automatic wait_for_vblank(output logic seen);
		int n;
		n = 0;
		while (!fb_vblank && n < wait_limit) begin
			step_clock();
			n++;
		end
		seen = fb_vblank;
		if (!seen) begin
			$display("timeout: vertical blank did not start within %0d clocks", wait_limit);
			other_errors++;
		end
	endtask

	task automatic wait_frames(input int frames);
		int n;
		int starts;
		logic prev;
		n = 0;
		starts = 0;
		prev = fb_vblank;
		while (starts < frames && n < (frames + 1) * frame_clocks) begin
			step_clock();
			if (fb_vblank && !prev)
				starts++;       // one vblank start per frame
			prev = fb_vblank;
			n++;
		end
		if (starts < frames) begin
			$display("timeout: saw %0d of %0d frames", starts, frames);
			other_errors++;
		end
	endtask

	// fills every palette entry and every cell, writing only in vblank
	task automatic load_memories();
		int i;
		logic [31:0] r;
		logic seen;
		i = 0;
		while (i < pal_depth) begin
			if (!fb_vblank) begin
				fb_wr_en = 1'b0;
				pal_wr_en = 1'b0;
				wait_for_vblank(seen);
				if (!seen)
					break;
			end
			r = $random(seed);
			pal_wr_en = 1'b1;
			pal_wr_addr = 8'(i);
			pal_wr_data = r[23:0];
			r = $random(seed);
			fb_wr_en = (i < fb_depth);   // cells go out with the first entries
			fb_wr_addr = addr_w'(i);
			fb_wr_data = r[16] ? {1'b1, r[14:0]} : {8'h00, r[7:0]};  // direct or indexed
			step_clock();
			i++;
		end
		fb_wr_en = 1'b0;
		pal_wr_en = 1'b0;
	endtask

	initial begin
		seed = 32'hbab4;
		reset_n = 1'b0;
		fb_wr_en = 1'b0;
		fb_wr_addr = '0;
		fb_wr_data = '0;
		pal_wr_en = 1'b0;
		pal_wr_addr = '0;
		pal_wr_data = '0;
		repeat (3) @(posedge vga_clk);
		#2;
		reset_n = 1'b1;
		load_memories();
		wait_frames(1);
		load_memories();    // rewrite with new values, seen from the next frame
		wait_frames(3);
		if (direct_count == 0 || indexed_count == 0) begin
			$display("no visible pixel came from a direct or an indexed cell");
			other_errors++;
		end
		$display("errors: %0d compare, %0d other", error_count, other_errors);
		if (error_count + other_errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: verif/vga_checker.sv
module vga_checker import vga_color_pkg::*; #(
	parameter int width = 16,
	parameter int h_front_porch = 2,
	parameter int h_sync = 3,
	parameter int h_back_porch = 2,
	parameter int height = 8,
	parameter int v_front_porch = 1,
	parameter int v_sync = 2,
	parameter int v_back_porch = 1,
	parameter int scale_shift = 1,
	localparam int fb_w = width >> scale_shift,
	localparam int fb_depth = fb_w * (height >> scale_shift),
	localparam int addr_w = $clog2(fb_depth)
) (
	input logic vga_clk,
	input logic reset_n,
	input logic fb_wr_en,
	input logic [addr_w-1:0] fb_wr_addr,
	input logic [15:0] fb_wr_data,
	input logic pal_wr_en,
	input logic [pal_idx_w-1:0] pal_wr_addr,
	input logic [23:0] pal_wr_data,
	input logic [chan_w-1:0] vga_red,
	input logic [chan_w-1:0] vga_green,
	input logic [chan_w-1:0] vga_blue,
	input logic vga_hsync,
	input logic vga_vsync,
	input logic fb_hblank,
	input logic fb_vblank,
	output int error_count,
	output int direct_count,   // visible pixels checked from direct cells
	output int indexed_count   // visible pixels checked through the palette
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int line_total = width + h_front_porch + h_sync + h_back_porch;
	localparam int frame_total = height + v_front_porch + v_sync + v_back_porch;
	localparam int hs_start = width + h_front_porch;  // first low pixel
	localparam int hs_end = hs_start + h_sync;        // first high pixel again
	localparam int vs_start = height + v_front_porch;
	localparam int vs_end = vs_start + v_sync;

	int x;   // model position, same reset as the controller
	int y;
	int errors = 0;
	int direct_seen = 0;
	int indexed_seen = 0;
	logic [15:0] fb_shadow [fb_depth];
	logic [23:0] pal_shadow [256];
	logic fb_known [fb_depth] = '{default: 1'b0};   // cell written at least once
	logic pal_known [256] = '{default: 1'b0};

	assign error_count = errors;
	assign direct_count = direct_seen;
	assign indexed_count = indexed_seen;

	always @(posedge vga_clk or negedge reset_n) begin
		if (!reset_n) begin
			x <= 0;
			y <= 0;
		end else if (x == line_total - 1) begin
			x <= 0;
			if (y == frame_total - 1)
				y <= 0;
			else
				y <= y + 1;
		end else
			x <= x + 1;
	end

	// shadows follow the write strobes, written on the same edge as the DUT
	always @(posedge vga_clk) begin
		if (fb_wr_en) begin
			fb_shadow[fb_wr_addr] <= fb_wr_data;
			fb_known[fb_wr_addr] <= 1'b1;
		end
		if (pal_wr_en) begin
			pal_shadow[pal_wr_addr] <= pal_wr_data;
			pal_known[pal_wr_addr] <= 1'b1;
		end
	end

	function automatic int cell_of(input int px, input int py);
		return (py >> scale_shift) * fb_w + (px >> scale_shift);  // 2**shift square cells
	endfunction

	// 5 bit channel to 8 bits, top three bits repeated underneath
	function automatic logic [7:0] scale5(input logic [4:0] c);
		logic [7:0] wide;
		wide = 8'(c) << 3;
		return wide | 8'(c >> 2);
	endfunction

	function automatic logic is_visible(input int px, input int py);
		return px < width && py < height;
	endfunction

	function automatic logic rgb_known(input int px, input int py);
		logic [15:0] word;
		if (!is_visible(px, py))
			return 1'b1;           // blank is always zero
		if (!fb_known[addr_w'(cell_of(px, py))])
			return 1'b0;
		word = fb_shadow[addr_w'(cell_of(px, py))];
		return word[15] || pal_known[word[7:0]];
	endfunction

	function automatic logic [23:0] expected_rgb(input int px, input int py);
		logic [15:0] word;
		if (!is_visible(px, py))
			return 24'h0;
		word = fb_shadow[addr_w'(cell_of(px, py))];
		if (word[15])              // direct 5-5-5
			return {scale5(word[14:10]), scale5(word[9:5]), scale5(word[4:0])};
		return pal_shadow[word[7:0]];  // low byte picks the palette entry
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (act !== exp) begin
			errors = errors + 1;
			$display("ERROR %0d ns: %s expected 'h%0h, actual 'h%0h", $time, name, exp, act);
		end
	endtask

	// outputs settle well before the falling edge
	always @(negedge vga_clk) begin
		logic [23:0] exp_rgb;
		logic [15:0] word;
		check_value("fb_hblank", 32'(x >= width), 32'(fb_hblank));
		check_value("fb_vblank", 32'(y >= height), 32'(fb_vblank));
		check_value("vga_hsync", 32'(!(x >= hs_start && x < hs_end)), 32'(vga_hsync));
		check_value("vga_vsync", 32'(!(y >= vs_start && y < vs_end)), 32'(vga_vsync));
		if (rgb_known(x, y)) begin
			exp_rgb = expected_rgb(x, y);
			check_value("vga_red", 32'(exp_rgb[23:16]), 32'(vga_red));
			check_value("vga_green", 32'(exp_rgb[15:8]), 32'(vga_green));
			check_value("vga_blue", 32'(exp_rgb[7:0]), 32'(vga_blue));
			if (is_visible(x, y)) begin
				word = fb_shadow[addr_w'(cell_of(x, y))];
				if (word[15])
					direct_seen = direct_seen + 1;
				else
					indexed_seen = indexed_seen + 1;
			end
		end
	end

endmodule

// File: src/vga_subsys.sv
module vga_subsys import vga_timing_pkg::*, vga_color_pkg::*; #(
	parameter int width = def_width,
	parameter int h_front_porch = def_h_front_porch,
	parameter int h_sync = def_h_sync,
	parameter int h_back_porch = def_h_back_porch,
	parameter int height = def_height,
	parameter int v_front_porch = def_v_front_porch,
	parameter int v_sync = def_v_sync,
	parameter int v_back_porch = def_v_back_porch,
	parameter int scale_shift = 2,  // 4x4 pixel cells by default
	localparam int fb_depth = (width >> scale_shift) * (height >> scale_shift),
	localparam int fb_addr_w = $clog2(fb_depth)
) (
	input logic vga_clk,
	input logic reset_n,

	// framebuffer load
	input logic fb_wr_en,
	input logic [fb_addr_w-1:0] fb_wr_addr,
	input pixel_word_t fb_wr_data,

	// palette load
	input logic pal_wr_en,
	input logic [pal_idx_w-1:0] pal_wr_addr,
	input rgb888_t pal_wr_data,

	output logic [7:0] vga_red,
	output logic [7:0] vga_green,
	output logic [7:0] vga_blue,
	output logic vga_hsync,
	output logic vga_vsync,
	output logic fb_hblank,   // tell the loader when it is safe to write
	output logic fb_vblank
);

	pixel_word_t fb_word;           // framebuffer to decoder
	logic [chan_w-1:0] red;         // decoder to controller
	logic [chan_w-1:0] green;
	logic [chan_w-1:0] blue;

	vga_ctl #(
		.width(width),
		.h_front_porch(h_front_porch),
		.h_sync(h_sync),
		.h_back_porch(h_back_porch),
		.height(height),
		.v_front_porch(v_front_porch),
		.v_sync(v_sync),
		.v_back_porch(v_back_porch)
	) u_ctl (
		.vga_clk(vga_clk),
		.reset_n(reset_n),
		.red(red),
		.green(green),
		.blue(blue),
		.vga_red(vga_red),
		.vga_green(vga_green),
		.vga_blue(vga_blue),
		.vga_hsync(vga_hsync),
		.vga_vsync(vga_vsync),
		.fb_hblank(fb_hblank),
		.fb_vblank(fb_vblank)
	);

	// scan tracker follows the same blank levels that leave the top
	fb_reader #(
		.width(width),
		.height(height),
		.scale_shift(scale_shift)
	) u_fb (
		.vga_clk(vga_clk),
		.reset_n(reset_n),
		.fb_hblank(fb_hblank),
		.fb_vblank(fb_vblank),
		.fb_wr_en(fb_wr_en),
		.fb_wr_addr(fb_wr_addr),
		.fb_wr_data(fb_wr_data),
		.fb_word(fb_word)
	);

	pixel_decode u_pal (
		.vga_clk(vga_clk),
		.fb_word(fb_word),
		.pal_wr_en(pal_wr_en),
		.pal_wr_addr(pal_wr_addr),
		.pal_wr_data(pal_wr_data),
		.red(red),
		.green(green),
		.blue(blue)
	);

endmodule

// File: src/pixel_decode.sv
module pixel_decode import vga_color_pkg::*; (
	input logic vga_clk,
	input pixel_word_t fb_word,  // current cell, straight from the framebuffer

	// palette write port
	input logic pal_wr_en,
	input logic [pal_idx_w-1:0] pal_wr_addr,
	input rgb888_t pal_wr_data,

	output logic [chan_w-1:0] red,   // to the controller's colour inputs
	output logic [chan_w-1:0] green,
	output logic [chan_w-1:0] blue
);

	localparam int pal_depth = 1 << pal_idx_w;

	rgb888_t pal_mem [pal_depth];  // 256 x 24
	rgb888_t pal_entry;            // entry picked by an indexed word

	// 5 bit field to full scale, top bits fill the bottom so 31 maps to 255
	function automatic logic [chan_w-1:0] widen5(input logic [4:0] c);
		return {c, c[4:2]};
	endfunction

	always_ff @(posedge vga_clk) begin
		if (pal_wr_en)
			pal_mem[pal_wr_addr] <= pal_wr_data;
	end

	assign pal_entry = pal_mem[fb_word.indexed.idx];  // read async

	always_comb begin
		if (fb_word.direct.mode) begin
			red = widen5(fb_word.direct.red5);
			green = widen5(fb_word.direct.green5);
			blue = widen5(fb_word.direct.blue5);
		end else begin
			red = pal_entry.red;
			green = pal_entry.green;
			blue = pal_entry.blue;
		end
	end

	// whatever loaded the framebuffer has to keep the spare bits clear
	a_rsvd_zero: assert property (@(posedge vga_clk)
		!fb_word.indexed.mode |-> fb_word.indexed.rsvd == '0);

endmodule

// File: src/fb_reader.sv
module fb_reader import vga_color_pkg::*; #(
	parameter int width = 800,       // visible pixels, from the top level
	parameter int height = 480,
	parameter int scale_shift = 2,   // cell side is 2**scale_shift pixels
	localparam int fb_w = width >> scale_shift,
	localparam int fb_h = height >> scale_shift,
	localparam int fb_depth = fb_w * fb_h,
	localparam int addr_w = $clog2(fb_depth)
) (
	input logic vga_clk,
	input logic reset_n,
	input logic fb_hblank,    // from vga_ctl
	input logic fb_vblank,

	// write port, cell written at the clock edge while fb_wr_en is high
	input logic fb_wr_en,
	input logic [addr_w-1:0] fb_wr_addr,
	input pixel_word_t fb_wr_data,

	output pixel_word_t fb_word  // cell under the current pixel, no latency
);

	localparam int col_w = $clog2(width + 1);   // column runs one past the edge
	localparam int row_w = $clog2(height + 1);
	localparam int ra_w = addr_w + 1;           // headroom for the range check

	pixel_word_t fb_mem [fb_depth];

	logic [col_w-1:0] col;   // screen column, tracks the controller's pixel
	logic [row_w-1:0] row;   // screen row
	logic hblank_q;          // blank level one clock back
	logic line_end;          // first hblank clock of a line
	logic visible;
	logic [ra_w-1:0] row_base;
	logic [ra_w-1:0] col_off;
	logic [ra_w-1:0] rd_addr;

	always_ff @(posedge vga_clk) begin
		if (fb_wr_en)
			fb_mem[fb_wr_addr] <= fb_wr_data;
	end

	assign line_end = fb_hblank && !hblank_q;
	assign visible = !fb_hblank && !fb_vblank;

	always_ff @(posedge vga_clk or negedge reset_n) begin
		if (!reset_n) begin
			col <= '0;
			row <= '0;
			hblank_q <= 1'b0;
		end else begin
			hblank_q <= fb_hblank;

			if (fb_hblank)
				col <= '0;            // ready for the next line
			else if (!fb_vblank)
				col <= col + 1'b1;

			if (fb_vblank)
				row <= '0;            // frame restarts at the top
			else if (line_end)
				row <= row + 1'b1;    // counted once per visible line
		end
	end

	// scaled cell coordinates, row major
	assign row_base = ra_w'(row >> scale_shift) * ra_w'(fb_w);
	assign col_off = ra_w'(col >> scale_shift);
	// during blank col and row may sit one past the edge, park on cell 0
	assign rd_addr = visible ? row_base + col_off : '0;

	assign fb_word = fb_mem[rd_addr[addr_w-1:0]];

	// the trackers must stay inside the visible area the controller reports
	a_rd_range: assert property (@(posedge vga_clk) disable iff (!reset_n)
		rd_addr < ra_w'(fb_depth));

endmodule

// File: src/vga_ctl.sv
module vga_ctl import vga_timing_pkg::*; #(
	parameter int width = def_width,
	parameter int h_front_porch = def_h_front_porch,
	parameter int h_sync = def_h_sync,
	parameter int h_back_porch = def_h_back_porch,
	parameter int height = def_height,
	parameter int v_front_porch = def_v_front_porch,
	parameter int v_sync = def_v_sync,
	parameter int v_back_porch = def_v_back_porch
) (
	input logic vga_clk,
	input logic reset_n,      // async, active low

	// colour from the pixel pipeline, valid in the same cycle as the position
	input logic [7:0] red,
	input logic [7:0] green,
	input logic [7:0] blue,

	output logic [7:0] vga_red,  // zero outside the visible area
	output logic [7:0] vga_green,
	output logic [7:0] vga_blue,
	output logic vga_hsync,      // active low at the pin
	output logic vga_vsync,

	// blank levels for the framebuffer side, combinational on position
	output logic fb_hblank,
	output logic fb_vblank
);

	localparam int pixels_per_line = width + h_front_porch + h_sync + h_back_porch;
	localparam int lines_per_frame = height + v_front_porch + v_sync + v_back_porch;
	localparam int xbits = $clog2(pixels_per_line);
	localparam int ybits = $clog2(lines_per_frame);

	// compare values sized to the counters
	localparam logic [xbits-1:0] x_last = xbits'(pixels_per_line - 1);
	localparam logic [ybits-1:0] y_last = ybits'(lines_per_frame - 1);
	localparam logic [xbits-1:0] x_vis = xbits'(width);
	localparam logic [ybits-1:0] y_vis = ybits'(height);
	localparam logic [xbits-1:0] hs_on = xbits'(width + h_front_porch - 1);
	localparam logic [xbits-1:0] hs_off = xbits'(width + h_front_porch + h_sync - 1);
	localparam logic [ybits-1:0] vs_on = ybits'(height + v_front_porch - 1);
	localparam logic [ybits-1:0] vs_off = ybits'(height + v_front_porch + v_sync - 1);

	logic [xbits-1:0] x_pos;  // pixel within the line
	logic [ybits-1:0] y_pos;  // line within the frame
	logic x_max, y_max;
	logic hsync_q, vsync_q;   // active high internally
	logic visible;

	assign x_max = (x_pos == x_last);
	assign y_max = (y_pos == y_last);

	assign fb_hblank = (x_pos >= x_vis);
	assign fb_vblank = (y_pos >= y_vis);
	assign visible = !fb_hblank && !fb_vblank;

	always_ff @(posedge vga_clk or negedge reset_n) begin
		if (!reset_n) begin
			x_pos <= '0;
			y_pos <= '0;
			hsync_q <= 1'b0;  // pins come out of reset inactive (high)
			vsync_q <= 1'b0;
		end else begin
			if (x_max) begin
				x_pos <= '0;
				y_pos <= y_max ? '0 : y_pos + 1'b1;  // wrap at the last line
			end else begin
				x_pos <= x_pos + 1'b1;
			end

			// register so the pulse starts exactly on the window's first pixel
			if (x_pos == hs_on)
				hsync_q <= 1'b1;
			else if (x_pos == hs_off)
				hsync_q <= 1'b0;

			// vsync moves only at line ends, so it spans whole lines
			if (x_max && y_pos == vs_on)
				vsync_q <= 1'b1;
			else if (x_max && y_pos == vs_off)
				vsync_q <= 1'b0;
		end
	end

	assign vga_hsync = ~hsync_q;
	assign vga_vsync = ~vsync_q;

	assign vga_red = visible ? red : '0;
	assign vga_green = visible ? green : '0;
	assign vga_blue = visible ? blue : '0;

	// registered pulse must line up with its counter window
	a_hsync_window: assert property (@(posedge vga_clk) disable iff (!reset_n)
		hsync_q |-> (x_pos > hs_on && x_pos <= hs_off));

	a_line_range: assert property (@(posedge vga_clk) disable iff (!reset_n)
		y_pos <= y_last);

endmodule

// File: src/vga_color_pkg.sv
package vga_color_pkg;

	localparam int chan_w = 8;    // bits per colour channel at the output
	localparam int pal_idx_w = 8; // 256 palette entries

	// one output colour, also the palette entry format
	typedef struct packed {
		logic [chan_w-1:0] red;
		logic [chan_w-1:0] green;
		logic [chan_w-1:0] blue;
	} rgb888_t;

	// direct colour word, mode bit set
	typedef struct packed {
		logic mode;        // 1 here
		logic [4:0] red5;
		logic [4:0] green5;
		logic [4:0] blue5;
	} pix_direct_t;

	// palette word, mode bit clear
	typedef struct packed {
		logic mode;                 // 0 here
		logic [6:0] rsvd;           // must be written as zero
		logic [pal_idx_w-1:0] idx;  // palette entry
	} pix_indexed_t;

	// one framebuffer cell, mode bit is the msb in both views
	typedef union packed {
		pix_direct_t direct;
		pix_indexed_t indexed;
	} pixel_word_t;

endpackage

// File: src/vga_timing_pkg.sv
package vga_timing_pkg;

	// default mode is 800x480, pixel clock around 33 MHz
	// horizontal values are in pixels
	localparam int def_width = 800;        // visible pixels per line
	localparam int def_h_front_porch = 32; // blank before hsync
	localparam int def_h_sync = 120;       // hsync pulse length
	localparam int def_h_back_porch = 32;  // blank after hsync

	// vertical values are in lines
	localparam int def_height = 480;       // visible lines per frame
	localparam int def_v_front_porch = 8;  // blank lines before vsync
	localparam int def_v_sync = 5;         // vsync pulse length in lines
	localparam int def_v_back_porch = 13;  // blank lines after vsync

	// line total = width + front porch + sync + back porch
	// frame total = height + front porch + sync + back porch
	// the whole vertical blank is the window for reloading the framebuffer
	// and the palette, that is a lot of clocks at this mode:
	// (8 + 5 + 13) lines times 984 pixels

endpackage
